// ==== hack_system.f ====
logic/hack_pkg.sv
logic/hack_alu.sv
logic/hack_cpu.sv
logic/hack_vram.sv
logic/hack_data_mem.sv
logic/hack_system.sv
verif/hack_system_sva.sv
verif/hack_system_checker.sv
verif/hack_system_tb.sv

// ==== Makefile ====
# Verilator build and run for the Hack system testbench

VERILATOR ?= verilator
TOP       ?= hack_system_tb
RTL_TOP   ?= hack_system
FLIST     ?= hack_system.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/hack_system_tb.sv ====
`timescale 1ns/1ps

module hack_system_tb;
  import hack_pkg::*;

  localparam int SCAN_BURST   = 16;
  localparam int SCAN_PERIOD  = 32;
  localparam int FULL_SCAN    = 8192 / SCAN_BURST * SCAN_PERIOD;
  localparam int RESET_CYCLES = 5;
  localparam int N_TESTS      = 4;
  localparam int MAX_ROWS     = 1024;

  // computation codes for D and A, in the order of the Hack table
  localparam logic [5:0] ALU_COMPS [18] = '{
    6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
    6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
    6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
  };
  localparam logic [5:0] C_ZERO  = 6'b101010;
  localparam logic [5:0] C_ONE   = 6'b111111;
  localparam logic [5:0] C_NEG1  = 6'b111010;
  localparam logic [5:0] C_D     = 6'b001100;
  localparam logic [5:0] C_A     = 6'b110000;
  localparam logic [5:0] C_NEG_A = 6'b110011;
  localparam logic [5:0] C_D_P1  = 6'b011111;
  localparam logic [5:0] C_A_P1  = 6'b110111;
  localparam logic [5:0] C_D_PA  = 6'b000010;

  logic       clk;
  logic       reset;
  word_t      instruction;
  word_t      prog_counter;
  logic       scan_valid;
  vram_addr_t scan_addr;
  word_t      scan_data;
  logic       test_end;
  int         test_id;
  int         mark_index;
  word_t      mark_expect;
  logic       run_end;
  int         errors;

  // program table with test id, instruction word and expected marked word
  int    row_test [MAX_ROWS];
  word_t row_inst [MAX_ROWS];
  word_t row_expect [MAX_ROWS];
  int    n_rows;
  int    test_start [N_TESTS];
  int    test_len [N_TESTS];
  int    mark_addr [N_TESTS];
  int    cur_test;
  int    cur_start;
  word_t cur_expect;
  logic [31:0] lcg_state;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  hack_system #(
    .SCAN_BURST  (SCAN_BURST),
    .SCAN_PERIOD (SCAN_PERIOD)
  ) dut0 (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .prog_counter (prog_counter),
    .scan_valid   (scan_valid),
    .scan_addr    (scan_addr),
    .scan_data    (scan_data)
  );

  hack_system_checker chk0 (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .prog_counter (prog_counter),
    .scan_valid   (scan_valid),
    .scan_addr    (scan_addr),
    .scan_data    (scan_data),
    .test_end     (test_end),
    .test_id      (test_id),
    .mark_index   (mark_index),
    .mark_expect  (mark_expect),
    .run_end      (run_end),
    .errors       (errors)
  );

  bind hack_cpu hack_system_sva sva0 (
    .clk          (clk),
    .reset        (reset),
    .mem_req      (mem_req),
    .busy         (busy),
    .prog_counter (prog_counter)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t c_word(input logic a, input logic [5:0] comp,
                                   input logic [2:0] dest, input logic [2:0] jmp);
    return {3'b111, a, comp, dest, jmp};
  endfunction

  // words past the end of a program read as @0
  function automatic word_t fetch_word(input int test, input word_t pc);
    if (int'(pc) >= test_len[test]) begin
      return 16'h0000;
    end
    return row_inst[test_start[test] + int'(pc)];
  endfunction

  task automatic emit(input word_t w);
    row_test[n_rows]   = cur_test;
    row_inst[n_rows]   = w;
    row_expect[n_rows] = cur_expect;
    n_rows++;
  endtask

  task automatic emit_a(input word_t v);
    emit({1'b0, v[14:0]});
  endtask

  task automatic begin_test(input int id, input int mark, input word_t expected);
    cur_test      = id;
    cur_start     = n_rows;
    mark_addr[id] = mark;
    cur_expect    = expected;
  endtask

  // every program ends in @n followed by an unconditional jump back to it
  task automatic end_program();
    emit_a(word_t'(n_rows - cur_start));
    emit(c_word(1'b0, C_ZERO, 3'b000, 3'b111));
  endtask

  // instruction ROM model, served at the current program counter
  always @(negedge clk) begin
    instruction <= fetch_word(cur_test, prog_counter);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int    i;
    int    j;
    int    k;
    int    n;
    int    r;
    int    t;
    int    tgt;
    int    max_len;
    word_t x;
    word_t y;
    reset       = 1'b1;
    instruction = 16'h0000;
    test_end    = 1'b0;
    run_end     = 1'b0;
    test_id     = 0;
    mark_index  = 0;
    mark_expect = 16'h0000;
    n_rows      = 0;
    cur_test    = 0;
    lcg_state   = 32'd32756;

    // every ALU function on random D and A, results to video RAM 0..17
    lcg_state = lcg_next(lcg_state);
    x = {1'b0, lcg_state[30:16]};
    lcg_state = lcg_next(lcg_state);
    y = {1'b0, lcg_state[30:16]};
    begin_test(0, 13, x + y);
    for (i = 0; i < 18; i++) begin
      emit_a(x);
      emit(c_word(1'b0, C_A, 3'b010, 3'b000));
      emit_a(y);
      emit(c_word(1'b0, ALU_COMPS[i], 3'b010, 3'b000));
      emit_a(word_t'(32'h4000 + i));
      emit(c_word(1'b0, C_D, 3'b001, 3'b000));
    end
    end_program();

    // all jump conditions on negative, zero and positive D
    begin_test(1, 16'h0100 + 23, 16'd7);
    n = 0;
    for (j = 0; j < 8; j++) begin
      for (k = 0; k < 3; k++) begin
        if (k == 0) begin
          emit_a(16'd5);
          emit(c_word(1'b0, C_NEG_A, 3'b010, 3'b000));
        end else if (k == 1) begin
          emit(c_word(1'b0, C_ZERO, 3'b010, 3'b000));
        end else begin
          emit_a(16'd7);
          emit(c_word(1'b0, C_A, 3'b010, 3'b000));
        end
        // a taken jump skips the increment of D
        tgt = n_rows - cur_start + 3;
        emit_a(word_t'(tgt));
        emit(c_word(1'b0, C_D, 3'b000, 3'(j)));
        emit(c_word(1'b0, C_D_P1, 3'b010, 3'b000));
        emit_a(word_t'(32'h4100 + n));
        emit(c_word(1'b0, C_D, 3'b001, 3'b000));
        n++;
      end
    end
    end_program();

    // main RAM stores, reloads and combined destinations
    begin_test(2, 16'h0200, 16'd102);
    emit_a(16'd100);
    emit(c_word(1'b0, C_ONE, 3'b001, 3'b000));
    emit_a(16'd101);
    emit(c_word(1'b0, C_NEG1, 3'b001, 3'b000));
    emit_a(16'd100);
    emit(c_word(1'b1, C_A, 3'b010, 3'b000));
    emit_a(16'd101);
    emit(c_word(1'b1, C_D_PA, 3'b010, 3'b000));
    emit_a(16'd100);
    emit(c_word(1'b1, C_A_P1, 3'b011, 3'b000));
    emit(c_word(1'b0, C_A, 3'b010, 3'b000));
    // AMD=D moves A to 100, so M must now hold the 2 stored there
    emit_a(16'd103);
    emit(c_word(1'b0, C_D, 3'b111, 3'b000));
    emit(c_word(1'b1, C_D_PA, 3'b010, 3'b000));
    emit_a(16'h4200);
    emit(c_word(1'b0, C_D, 3'b001, 3'b000));
    emit_a(16'd103);
    emit(c_word(1'b1, C_A, 3'b010, 3'b000));
    emit_a(16'h4201);
    emit(c_word(1'b0, C_D, 3'b001, 3'b000));
    end_program();

    // video RAM stores under scanning, then reads copied to other words
    begin_test(3, 16'h0400 + 15, 16'h1fff);
    for (i = 0; i < 16; i++) begin
      emit_a(word_t'(32'h1000 + i * 32'h111));
      emit(c_word(1'b0, C_A, 3'b010, 3'b000));
      emit_a(word_t'(32'h4300 + i));
      emit(c_word(1'b0, C_D, 3'b001, 3'b000));
    end
    for (i = 0; i < 16; i++) begin
      emit_a(word_t'(32'h4300 + i));
      emit(c_word(1'b1, C_A, 3'b010, 3'b000));
      emit_a(word_t'(32'h4400 + i));
      emit(c_word(1'b0, C_D, 3'b001, 3'b000));
    end
    end_program();

    // test boundaries come from the id column of the table
    for (t = 0; t < N_TESTS; t++) begin
      test_len[t] = 0;
    end
    for (r = 0; r < n_rows; r++) begin
      if (r == 0 || row_test[r] != row_test[r-1]) begin
        test_start[row_test[r]] = r;
      end
      test_len[row_test[r]]++;
    end
    max_len = 0;
    for (t = 0; t < N_TESTS; t++) begin
      if (test_len[t] > max_len) begin
        max_len = test_len[t];
      end
    end
    cycle_limit = N_TESTS * (max_len * 20 + FULL_SCAN + 2 * SCAN_PERIOD + RESET_CYCLES + 4);

    for (t = 0; t < N_TESTS; t++) begin
      @(negedge clk);
      cur_test = t;
      reset    = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      // the self-loop starts two words before the end of the program
      while (prog_counter != word_t'(test_len[t] - 2)) begin
        @(negedge clk);
      end
      repeat (FULL_SCAN + 2 * SCAN_PERIOD) @(negedge clk);
      test_id     = t;
      mark_index  = mark_addr[t];
      mark_expect = row_expect[test_start[t]];
      test_end    = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
    end
    run_end = 1'b1;
    @(negedge clk);
    run_end = 1'b0;
    @(negedge clk);
    // the bound assertions count their own failures next to the checker errors
    if (errors == 0 && dut0.cpu0.sva0.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/hack_system_checker.sv ====
`timescale 1ns/1ps

module hack_system_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  hack_pkg::word_t      instruction,
  input  hack_pkg::word_t      prog_counter,
  input  logic                 scan_valid,
  input  hack_pkg::vram_addr_t scan_addr,
  input  hack_pkg::word_t      scan_data,
  input  logic                 test_end,
  input  int                   test_id,
  input  int                   mark_index,
  input  hack_pkg::word_t      mark_expect,
  input  logic                 run_end,
  output int                   errors
);
  import hack_pkg::*;

  // ISA model state, the memory image is keyed by full data address
  word_t a_m;
  word_t d_m;
  word_t pc_m;
  word_t last_pc;
  word_t held_inst;
  word_t dmem [int];

  // image the scanner should see, plus the last word scanned per index
  word_t scan_img [int];
  word_t last_scan [int];

  // the scanner steps one word at a time and wraps over the whole array
  vram_addr_t scan_next;
  logic       scan_seen;

  // video RAM stores reach the scan image two cycles late
  logic  new_valid;
  int    new_addr;
  word_t new_data;
  logic  p1_valid;
  int    p1_addr;
  word_t p1_data;
  logic  p2_valid;
  int    p2_addr;
  word_t p2_data;

  int checks;
  int test_checks;
  int test_errors;
  int tests_done;

  initial begin
    errors      = 0;
    checks      = 0;
    test_checks = 0;
    test_errors = 0;
    tests_done  = 0;
    p1_valid    = 1'b0;
    p2_valid    = 1'b0;
    new_valid   = 1'b0;
    scan_seen   = 1'b0;
  end

  // result of each entry of the Hack computation table, y is A or M
  function automatic word_t comp_eval(input logic [5:0] c, input word_t d, input word_t y);
    case (c)
      6'b101010: return 16'd0;
      6'b111111: return 16'd1;
      6'b111010: return 16'hffff;
      6'b001100: return d;
      6'b110000: return y;
      6'b001101: return ~d;
      6'b110001: return ~y;
      6'b001111: return -d;
      6'b110011: return -y;
      6'b011111: return d + 16'd1;
      6'b110111: return y + 16'd1;
      6'b001110: return d - 16'd1;
      6'b110010: return y - 16'd1;
      6'b000010: return d + y;
      6'b010011: return d - y;
      6'b000111: return y - d;
      6'b000000: return d & y;
      6'b010101: return d | y;
      default:   return 16'hxxxx;
    endcase
  endfunction

  // unmapped addresses read as zero
  function automatic word_t mem_value(input word_t addr);
    if (addr > VRAM_LIMIT || !dmem.exists(int'(addr))) begin
      return 16'd0;
    end
    return dmem[int'(addr)];
  endfunction

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    errors++;
    test_errors++;
  endtask

  // one instruction of the Hack ISA on the model state
  task automatic execute(input word_t inst);
    word_t y;
    word_t r;
    word_t a_old;
    logic  jump;
    a_old = a_m;
    if (!inst[15]) begin
      a_m  = inst;
      pc_m = pc_m + 16'd1;
    end else begin
      y = inst[12] ? mem_value(a_m) : a_m;
      r = comp_eval(inst[11:6], d_m, y);
      jump = (inst[2] && r[15]) || (inst[1] && r == 16'd0) ||
             (inst[0] && !r[15] && r != 16'd0);
      // the store goes to the address held before this instruction
      if (inst[3] && a_old <= VRAM_LIMIT) begin
        dmem[int'(a_old)] = r;
        if (a_old >= VRAM_BASE) begin
          new_valid = 1'b1;
          new_addr  = int'(a_old - VRAM_BASE);
          new_data  = r;
        end
      end
      if (inst[5]) begin
        a_m = r;
      end
      if (inst[4]) begin
        d_m = r;
      end
      pc_m = jump ? a_old : pc_m + 16'd1;
    end
  endtask

  always @(posedge clk) begin
    new_valid = 1'b0;
    // a store the model made two edges ago is already seen by the read sampled now
    if (p2_valid) begin
      scan_img[p2_addr] = p2_data;
    end
    // scan data on the outputs was read from the array two edges earlier
    if (scan_valid) begin
      if (scan_seen) begin
        checks++;
        test_checks++;
        if (scan_addr !== scan_next) begin
          report_mismatch("scan_addr", word_t'(scan_next), word_t'(scan_addr));
        end
      end
      scan_seen = 1'b1;
      scan_next = scan_addr + 1'b1;
      last_scan[int'(scan_addr)] = scan_data;
      if (scan_img.exists(int'(scan_addr))) begin
        checks++;
        test_checks++;
        if (scan_data !== scan_img[int'(scan_addr)]) begin
          report_mismatch("scan_data", scan_img[int'(scan_addr)], scan_data);
        end
      end
    end
    if (reset) begin
      a_m       = 16'd0;
      d_m       = 16'd0;
      pc_m      = 16'd0;
      last_pc   = 16'd0;
      scan_seen = 1'b0;
    end else if (prog_counter != last_pc) begin
      // a new program counter means the held instruction has completed
      execute(held_inst);
      checks++;
      test_checks++;
      if (prog_counter !== pc_m) begin
        report_mismatch("prog_counter", pc_m, prog_counter);
        pc_m = prog_counter;
      end
      last_pc = prog_counter;
    end
    held_inst = instruction;
    p2_valid  = p1_valid;
    p2_addr   = p1_addr;
    p2_data   = p1_data;
    p1_valid  = new_valid;
    p1_addr   = new_addr;
    p1_data   = new_data;
    if (test_end) begin
      checks++;
      test_checks++;
      if (!last_scan.exists(mark_index)) begin
        $display("test %0d: marked video RAM word %0d was never scanned", test_id, mark_index);
        errors++;
        test_errors++;
      end else if (last_scan[mark_index] !== mark_expect) begin
        report_mismatch("marked video RAM word", mark_expect, last_scan[mark_index]);
      end
      $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errors);
      tests_done++;
      test_checks = 0;
      test_errors = 0;
    end
    if (run_end) begin
      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    end
  end

endmodule

// ==== verif/hack_system_sva.sv ====
`timescale 1ns/1ps

module hack_system_sva (
  input logic               clk,
  input logic               reset,
  input hack_pkg::mem_req_t mem_req,
  input logic               busy,
  input hack_pkg::word_t    prog_counter
);
  import hack_pkg::*;

  logic vram_hit;

  // number of assertion failures seen so far
  int fail_count = 0;

  // the request address falls inside the shared video RAM window
  assign vram_hit = (mem_req.address >= VRAM_BASE) && (mem_req.address <= VRAM_LIMIT);

  // the scanner owns the port while busy, so no store may go out then
  no_store_while_busy: assert property (@(posedge clk) disable iff (reset)
    (mem_req.load && vram_hit) |-> !busy)
    else begin
      fail_count = fail_count + 1;
      $error("video RAM store issued while the scanner holds the port");
    end

  // reset leaves the CPU at address zero with the write strobe low
  reset_state: assert property (@(posedge clk)
    reset |=> (prog_counter == 16'd0) && !mem_req.load)
    else begin
      fail_count = fail_count + 1;
      $error("CPU did not come out of reset at address zero with load low");
    end

  // the strobe must always be a clean level once running
  load_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_req.load))
    else begin
      fail_count = fail_count + 1;
      $error("write strobe is unknown");
    end

endmodule

// ==== logic/hack_system.sv ====
`timescale 1ns/1ps

module hack_system #(
  parameter int RAM_WORDS   = 16384,
  parameter int SCAN_BURST  = 16,
  parameter int SCAN_PERIOD = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  hack_pkg::word_t      instruction,
  output hack_pkg::word_t      prog_counter,
  output logic                 scan_valid,
  output hack_pkg::vram_addr_t scan_addr,
  output hack_pkg::word_t      scan_data
);
  import hack_pkg::*;

  // request from the CPU and the data and stall level coming back
  mem_req_t mem_req;
  word_t    rdata;
  logic     busy;

  // the instruction ROM sits outside, addressed by prog_counter
  hack_cpu cpu0 (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .prog_counter (prog_counter),
    .mem_req      (mem_req),
    .rdata        (rdata),
    .busy         (busy)
  );

  // main RAM and the shared video RAM with its scanner
  hack_data_mem #(
    .RAM_WORDS   (RAM_WORDS),
    .SCAN_BURST  (SCAN_BURST),
    .SCAN_PERIOD (SCAN_PERIOD)
  ) data_mem0 (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .rdata      (rdata),
    .busy       (busy),
    .scan_valid (scan_valid),
    .scan_addr  (scan_addr),
    .scan_data  (scan_data)
  );

endmodule

// ==== logic/hack_data_mem.sv ====
`timescale 1ns/1ps

module hack_data_mem #(
  parameter int RAM_WORDS   = 16384,
  parameter int SCAN_BURST  = 16,
  parameter int SCAN_PERIOD = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  hack_pkg::mem_req_t   mem_req,
  output hack_pkg::word_t      rdata,
  output logic                 busy,
  output logic                 scan_valid,
  output hack_pkg::vram_addr_t scan_addr,
  output hack_pkg::word_t      scan_data
);
  import hack_pkg::*;

  localparam int RAM_AW = $clog2(RAM_WORDS);

  word_t ram [0:RAM_WORDS-1];

  logic       in_ram;
  logic       in_vram;
  word_t      vram_offset;
  vram_addr_t vram_addr;
  word_t      vram_rdata;

  // region decode, anything above the video RAM window is unmapped
  assign in_ram  = mem_req.address < VRAM_BASE;
  assign in_vram = (mem_req.address >= VRAM_BASE) && (mem_req.address <= VRAM_LIMIT);

  assign vram_offset = mem_req.address - VRAM_BASE;
  assign vram_addr   = vram_offset[$bits(vram_addr_t)-1:0];

  // main RAM is written on the strobe edge and read without a register
  always_ff @(posedge clk) begin
    if (mem_req.load && in_ram) begin
      ram[mem_req.address[RAM_AW-1:0]] <= mem_req.wdata;
    end
  end

  // unmapped addresses read as zero
  assign rdata = in_ram  ? ram[mem_req.address[RAM_AW-1:0]] :
                 in_vram ? vram_rdata : '0;

  hack_vram #(
    .SCAN_BURST  (SCAN_BURST),
    .SCAN_PERIOD (SCAN_PERIOD)
  ) vram0 (
    .clk        (clk),
    .reset      (reset),
    .cpu_addr   (vram_addr),
    .cpu_wdata  (mem_req.wdata),
    .cpu_write  (mem_req.load && in_vram),
    .cpu_rdata  (vram_rdata),
    .busy       (busy),
    .scan_valid (scan_valid),
    .scan_addr  (scan_addr),
    .scan_data  (scan_data)
  );

endmodule

// ==== logic/hack_vram.sv ====
`timescale 1ns/1ps

module hack_vram #(
  parameter int SCAN_BURST  = 16,
  parameter int SCAN_PERIOD = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  hack_pkg::vram_addr_t cpu_addr,
  input  hack_pkg::word_t      cpu_wdata,
  input  logic                 cpu_write,
  output hack_pkg::word_t      cpu_rdata,
  output logic                 busy,
  output logic                 scan_valid,
  output hack_pkg::vram_addr_t scan_addr,
  output hack_pkg::word_t      scan_data
);
  import hack_pkg::*;

  localparam int CNT_W = $clog2(SCAN_PERIOD);
  localparam int DEPTH = 2 ** $bits(vram_addr_t);

  word_t mem [0:DEPTH-1];

  logic [CNT_W-1:0] period_cnt;
  vram_addr_t scan_ptr;
  vram_addr_t port_addr;

  // two register stages behind the array read, shared by CPU and scanner
  word_t      data_s1;
  word_t      data_s2;
  vram_addr_t addr_s1;
  vram_addr_t addr_s2;
  logic       valid_s1;
  logic       valid_s2;

  // the scanner takes the single port for the whole burst
  assign port_addr = busy ? scan_ptr : cpu_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      period_cnt <= '0;
      busy       <= 1'b0;
      scan_ptr   <= '0;
      valid_s1   <= 1'b0;
      valid_s2   <= 1'b0;
    end else begin
      period_cnt <= (period_cnt == CNT_W'(SCAN_PERIOD - 1)) ? '0 : period_cnt + 1'b1;
      // a burst opens at the period wrap and covers the first SCAN_BURST counts
      if (period_cnt == CNT_W'(SCAN_PERIOD - 1)) begin
        busy <= 1'b1;
      end else if (period_cnt == CNT_W'(SCAN_BURST - 1)) begin
        busy <= 1'b0;
      end
      // the scan address wraps over the whole array from one burst to the next
      if (busy) begin
        scan_ptr <= scan_ptr + 1'b1;
      end
      valid_s1 <= busy;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    // CPU stores only reach the array while the scanner is idle
    if (cpu_write && !busy) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    data_s1 <= mem[port_addr];
    data_s2 <= data_s1;
    addr_s1 <= scan_ptr;
    addr_s2 <= addr_s1;
  end

  assign cpu_rdata  = data_s2;
  assign scan_data  = data_s2;
  assign scan_addr  = addr_s2;
  assign scan_valid = valid_s2;

endmodule

// ==== logic/hack_cpu.sv ====
`timescale 1ns/1ps

module hack_cpu (
  input  logic               clk,
  input  logic               reset,
  input  hack_pkg::word_t    instruction,
  output hack_pkg::word_t    prog_counter,
  output hack_pkg::mem_req_t mem_req,
  input  hack_pkg::word_t    rdata,
  input  logic               busy
);
  import hack_pkg::*;

  cpu_state_t state;

  // architectural registers plus a cached copy of the word at address A
  word_t a_reg;
  word_t d_reg;
  word_t m_reg;

  // operands and control captured at decode for the write_back cycle
  word_t     alu_x;
  word_t     alu_y;
  alu_ctrl_t alu_ctrl;
  logic [2:0] dest;
  logic [2:0] jmp;

  word_t alu_out;
  logic  alu_zero;
  logic  alu_neg;
  logic  alu_pos;
  logic  jump;

  // set once the video RAM port has been seen free for the pending read
  logic mem_wait;

  logic c_inst;
  logic a_sel;
  logic fast_mem;
  logic wb_ready;

  // bit 15 separates C-instructions from A-instructions
  assign c_inst = instruction[15];

  // the a bit chooses M instead of A as the second ALU operand
  assign a_sel = instruction[12];

  // anything outside the video RAM window is completed in a single cycle
  assign fast_mem = (a_reg < VRAM_BASE) || (a_reg > VRAM_LIMIT);

  // write_back may only finish once a video RAM store can reach the port
  assign wb_ready = !dest[0] || fast_mem || !busy;

  assign alu_pos = !(alu_neg || alu_zero);
  assign jump = (jmp[2] && alu_neg) || (jmp[1] && alu_zero) || (jmp[0] && alu_pos);

  // memory always sees A as the address and the ALU result as write data
  assign mem_req.address = a_reg;
  assign mem_req.wdata   = alu_out;
  assign mem_req.load    = (state == write_back) && dest[0] && (fast_mem || !busy);

  hack_alu alu0 (
    .x      (alu_x),
    .y      (alu_y),
    .ctrl   (alu_ctrl),
    .result (alu_out),
    .zero   (alu_zero),
    .neg    (alu_neg)
  );

  // decoded fields only matter in write_back, which always follows decode
  always_ff @(posedge clk) begin
    if (state == inst_decode && c_inst) begin
      alu_x    <= d_reg;
      alu_y    <= a_sel ? m_reg : a_reg;
      alu_ctrl <= alu_ctrl_t'(instruction[11:6]);
      dest     <= instruction[5:3];
      jmp      <= instruction[2:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= inst_fetch;
      prog_counter <= '0;
      a_reg        <= '0;
      d_reg        <= '0;
      m_reg        <= '0;
      mem_wait     <= 1'b0;
    end else begin
      case (state)
        // the instruction word settles at the new program counter
        inst_fetch: begin
          state <= inst_decode;
        end

        inst_decode: begin
          if (c_inst) begin
            state <= write_back;
          end else begin
            // an A-instruction moves the address, so M has to be reloaded
            a_reg        <= instruction;
            prog_counter <= prog_counter + 16'd1;
            state        <= mem_read;
          end
        end

        write_back: begin
          if (wb_ready) begin
            if (dest[2]) begin
              a_reg <= alu_out;
            end
            if (dest[1]) begin
              d_reg <= alu_out;
            end
            // the store goes to the old A, so the cache follows it directly
            if (dest[0]) begin
              m_reg <= alu_out;
            end
            prog_counter <= jump ? a_reg : prog_counter + 16'd1;
            // a new A needs the word at the new address before going on
            state <= dest[2] ? mem_read : inst_fetch;
          end
        end

        mem_read: begin
          if (fast_mem) begin
            state <= mem_fetch;
          end else if (!mem_wait) begin
            // the address is on the port in the first cycle busy is low
            mem_wait <= !busy;
          end else begin
            // one more cycle here and the pipelined data lands in mem_fetch
            state <= mem_fetch;
          end
        end

        mem_fetch: begin
          m_reg    <= rdata;
          mem_wait <= 1'b0;
          // the next instruction is already presented, so fetch is skipped
          state    <= inst_decode;
        end

        default: begin
          state <= inst_fetch;
        end
      endcase
    end
  end

endmodule

// ==== logic/hack_alu.sv ====
`timescale 1ns/1ps

module hack_alu (
  input  hack_pkg::word_t     x,
  input  hack_pkg::word_t     y,
  input  hack_pkg::alu_ctrl_t ctrl,
  output hack_pkg::word_t     result,
  output logic                zero,
  output logic                neg
);
  import hack_pkg::*;

  word_t x_zeroed;
  word_t x_final;
  word_t y_zeroed;
  word_t y_final;
  word_t f_out;

  // each operand is first optionally forced to zero, then optionally inverted
  assign x_zeroed = ctrl.zx ? '0 : x;
  assign x_final  = ctrl.nx ? ~x_zeroed : x_zeroed;
  assign y_zeroed = ctrl.zy ? '0 : y;
  assign y_final  = ctrl.ny ? ~y_zeroed : y_zeroed;

  // f picks between the adder and the bitwise and
  assign f_out = ctrl.f ? (x_final + y_final) : (x_final & y_final);

  // the output inversion gives the negations and the constant -1 and 1 cases
  assign result = ctrl.no ? ~f_out : f_out;

  // flags feed the jump conditions in the CPU
  assign zero = (result == '0);

  // the sign bit marks a negative two's complement result
  assign neg = result[15];

endmodule

// ==== logic/hack_pkg.sv ====
package hack_pkg;

  // one machine word serves as data, address and instruction
  typedef logic [15:0] word_t;

  // word index inside the 8K-word video RAM
  typedef logic [12:0] vram_addr_t;

  // ALU control bits in instruction order, so zx maps to instruction bit 11
  typedef struct packed {
    logic zx;
    logic nx;
    logic zy;
    logic ny;
    logic f;
    logic no;
  } alu_ctrl_t;

  // CPU memory request; load is the write strobe for the addressed word
  typedef struct packed {
    word_t address;
    word_t wdata;
    logic  load;
  } mem_req_t;

  typedef enum logic [2:0] {
    inst_fetch,
    inst_decode,
    write_back,
    mem_read,
    mem_fetch
  } cpu_state_t;

  // video RAM window in the data address map
  localparam word_t VRAM_BASE  = 16'h4000;
  localparam word_t VRAM_LIMIT = 16'h5fff;

endpackage
